// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = ct_tunnel_tb
FILELIST  = ct_tunnel_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== ct_tunnel_top.f ====
+incdir+design
design/ct_pkg.sv
design/ct_link_fsm.sv
design/ct_credit_counter.sv
design/ct_tx_mux.sv
design/ct_rx_demux.sv
design/ct_chan_fifo.sv
design/ct_tunnel_top.sv
verif/ct_tunnel_checker.sv
verif/ct_tunnel_tb.sv

// ==== design/ct_chan_fifo.sv ====
`timescale 1ns/1ps
`include "ct_macros.svh"

module ct_chan_fifo
(
  input  logic                      core_clk_i,
  input  logic                      arst_n_i,
  input  logic                      wr_v_i,
  input  logic [`CT_PAYLOAD_W-1:0]  wr_data_i,
  input  logic                      out_ready_i,
  input  logic                      credit_sent_i,
  output logic                      out_v_o,
  output logic [`CT_PAYLOAD_W-1:0]  out_data_o,
  output ct_pkg::cnt_t              owe_count_o,
  output logic                      empty_o
);

  import ct_pkg::*;

  localparam int ptr_w = $clog2(`CT_FIFO_DEPTH);

  logic [`CT_PAYLOAD_W-1:0] mem_q [`CT_FIFO_DEPTH];
  logic [ptr_w-1:0]         wr_ptr_q;
  logic [ptr_w-1:0]         rd_ptr_q;
  cnt_t                     count_q;
  cnt_t                     owe_q;
  logic                     deq;

  assign deq = out_v_o && out_ready_i;

  // Credits guarantee a free entry on every write.
  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      owe_q    <= '0;
    end
    else
    begin
      if (wr_v_i)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (deq)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + cnt_t'(wr_v_i) - cnt_t'(deq);
      // A dequeue alongside the credit flit stays owed.
      owe_q <= (credit_sent_i ? '0 : owe_q) + cnt_t'(deq);
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (wr_v_i)
    begin
      mem_q[wr_ptr_q] <= wr_data_i;
    end
  end

  assign out_v_o     = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];
  assign empty_o     = (count_q == '0);
  assign owe_count_o = owe_q;

endmodule

// ==== design/ct_credit_counter.sv ====
`timescale 1ns/1ps
`include "ct_macros.svh"

module ct_credit_counter
(
  input  logic                      core_clk_i,
  input  logic                      arst_n_i,
  input  logic                      credit_load_i,
  input  logic                      send_i,
  input  ct_pkg::ch_id_t            send_ch_i,
  input  logic                      ret_v_i,
  input  ct_pkg::ch_id_t            ret_ch_i,
  input  ct_pkg::cnt_t              ret_cnt_i,
  output logic [`CT_NUM_CH-1:0]     has_credit_o
);

  import ct_pkg::*;

  cnt_t [`CT_NUM_CH-1:0] credit_q;
  cnt_t [`CT_NUM_CH-1:0] credit_d;

  // Send and return may hit the same channel in one cycle.
  always_comb
  begin
    for (int c = 0; c < `CT_NUM_CH; c++)
    begin
      credit_d[c] = credit_q[c];
      if (ret_v_i && (ret_ch_i == ch_id_t'(c)))
      begin
        credit_d[c] = credit_d[c] + ret_cnt_i;
      end
      if (send_i && (send_ch_i == ch_id_t'(c)))
      begin
        credit_d[c] = credit_d[c] - cnt_t'(1);
      end
      has_credit_o[c] = (credit_q[c] != '0);
    end
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      credit_q <= '0;
    end
    else if (credit_load_i)
    begin
      credit_q <= {`CT_NUM_CH{cnt_t'(`CT_FIFO_DEPTH)}};
    end
    else
    begin
      credit_q <= credit_d;
    end
  end

endmodule

// ==== design/ct_link_fsm.sv ====
`timescale 1ns/1ps
`include "ct_macros.svh"

module ct_link_fsm
(
  input  logic                              core_clk_i,
  input  logic                              arst_n_i,
  input  ct_pkg::cnt_t [`CT_NUM_CH-1:0]     owe_count_i,
  input  logic [`CT_NUM_CH-1:0]             empty_i,
  output logic                              run_o,
  output logic                              credit_load_o,
  output logic                              credit_slot_o,
  output logic [`CT_NUM_CH-1:0]             credit_sent_o,
  output ct_pkg::ch_id_t                    credit_ch_o
);

  import ct_pkg::*;

  localparam logic [1:0] st_reset = 2'd0;
  localparam logic [1:0] st_load  = 2'd1;
  localparam logic [1:0] st_run   = 2'd2;

  logic [1:0] state_q;
  ch_id_t     rr_ptr_q;

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q  <= st_reset;
      rr_ptr_q <= '0;
    end
    else
    begin
      case (state_q)
        st_reset: state_q <= st_load;
        st_load:  state_q <= st_run;
        default:  state_q <= st_run;
      endcase
      // Next scan starts after the channel just served.
      if (credit_slot_o)
      begin
        rr_ptr_q <= credit_ch_o + ch_id_t'(1);
      end
    end
  end

  assign run_o         = (state_q == st_run);
  assign credit_load_o = (state_q == st_load);

  // Round-robin search for a channel owing a credit flit.
  always_comb
  begin : credit_scan
    ch_id_t idx;
    logic   owes;
    credit_slot_o = 1'b0;
    credit_ch_o   = '0;
    credit_sent_o = '0;
    for (int i = 0; i < `CT_NUM_CH; i++)
    begin
      idx  = rr_ptr_q + ch_id_t'(i);
      owes = (owe_count_i[idx] >= cnt_t'(`CT_CREDIT_DECIM)) ||
             ((owe_count_i[idx] != '0) && empty_i[idx]);
      if (run_o && !credit_slot_o && owes)
      begin
        credit_slot_o = 1'b1;
        credit_ch_o   = idx;
      end
    end
    if (credit_slot_o)
    begin
      credit_sent_o[credit_ch_o] = 1'b1;
    end
  end

endmodule

// ==== design/ct_macros.svh ====
`ifndef CT_MACROS_SVH
`define CT_MACROS_SVH

// Logical channels sharing the link.
`define CT_NUM_CH 4

// Payload bits carried by one data flit.
`define CT_PAYLOAD_W 16

// Receive buffer depth per channel.
// Also the credit count loaded at init.
`define CT_FIFO_DEPTH 4

// Credits are returned in batches of this size.
`define CT_CREDIT_DECIM 2

// Width of a channel id.
`define CT_CH_W 2

// Width of a credit count holding 0 to CT_FIFO_DEPTH.
`define CT_CNT_W 3

`endif

// ==== design/ct_pkg.sv ====
`include "ct_macros.svh"

package ct_pkg;

  typedef logic [`CT_CH_W-1:0] ch_id_t;

  typedef logic [`CT_CNT_W-1:0] cnt_t;

  typedef enum logic
  {
    flit_data   = 1'b0,
    flit_credit = 1'b1
  } flit_kind_e;

  typedef struct packed
  {
    ch_id_t                    ch;
    logic [`CT_PAYLOAD_W-1:0]  payload;
  } data_view_s;

  // Credit view padded out to the data view width.
  typedef struct packed
  {
    ch_id_t                              ch;
    cnt_t                                cnt;
    logic [`CT_PAYLOAD_W-`CT_CNT_W-1:0]  pad;
  } credit_view_s;

  typedef union packed
  {
    data_view_s   data;
    credit_view_s credit;
  } flit_body_u;

  typedef struct packed
  {
    flit_kind_e kind;
    flit_body_u body;
  } link_word_s;

endpackage

// ==== design/ct_rx_demux.sv ====
`timescale 1ns/1ps
`include "ct_macros.svh"

module ct_rx_demux
(
  input  logic                                      link_v_i,
  input  ct_pkg::link_word_s                        link_data_i,
  output logic [`CT_NUM_CH-1:0]                     wr_v_o,
  output logic [`CT_NUM_CH-1:0][`CT_PAYLOAD_W-1:0]  wr_data_o,
  output logic                                      ret_v_o,
  output ct_pkg::ch_id_t                            ret_ch_o,
  output ct_pkg::cnt_t                              ret_cnt_o
);

  import ct_pkg::*;

  logic is_data;
  logic is_credit;

  assign is_data   = link_v_i && (link_data_i.kind == flit_data);
  assign is_credit = link_v_i && (link_data_i.kind == flit_credit);

  // Data view steers the payload to its channel buffer.
  always_comb
  begin
    for (int c = 0; c < `CT_NUM_CH; c++)
    begin
      wr_v_o[c]    = is_data && (link_data_i.body.data.ch == ch_id_t'(c));
      wr_data_o[c] = link_data_i.body.data.payload;
    end
  end

  // Credit view goes back to the local counters.
  assign ret_v_o   = is_credit;
  assign ret_ch_o  = link_data_i.body.credit.ch;
  assign ret_cnt_o = link_data_i.body.credit.cnt;

endmodule

// ==== design/ct_tunnel_top.sv ====
`timescale 1ns/1ps
`include "ct_macros.svh"

module ct_tunnel_top
(
  input  logic                                      core_clk_i,
  input  logic                                      arst_n_i,
  input  logic [`CT_NUM_CH-1:0]                     in_v_i,
  input  logic [`CT_NUM_CH-1:0][`CT_PAYLOAD_W-1:0]  in_data_i,
  output logic [`CT_NUM_CH-1:0]                     in_ready_o,
  output logic [`CT_NUM_CH-1:0]                     out_v_o,
  output logic [`CT_NUM_CH-1:0][`CT_PAYLOAD_W-1:0]  out_data_o,
  input  logic [`CT_NUM_CH-1:0]                     out_ready_i,
  output logic                                      link_v_o,
  output ct_pkg::link_word_s                        link_data_o,
  input  logic                                      link_v_i,
  input  ct_pkg::link_word_s                        link_data_i
);

  import ct_pkg::*;

  logic                                      run;
  logic                                      credit_load;
  logic                                      credit_slot;
  logic [`CT_NUM_CH-1:0]                     credit_sent;
  ch_id_t                                    credit_ch;
  cnt_t [`CT_NUM_CH-1:0]                     owe_count;
  logic [`CT_NUM_CH-1:0]                     empty;
  logic [`CT_NUM_CH-1:0]                     has_credit;
  logic                                      send;
  ch_id_t                                    send_ch;
  logic                                      ret_v;
  ch_id_t                                    ret_ch;
  cnt_t                                      ret_cnt;
  logic [`CT_NUM_CH-1:0]                     wr_v;
  logic [`CT_NUM_CH-1:0][`CT_PAYLOAD_W-1:0]  wr_data;

  ct_link_fsm u_fsm
  (
    .core_clk_i    (core_clk_i),
    .arst_n_i      (arst_n_i),
    .owe_count_i   (owe_count),
    .empty_i       (empty),
    .run_o         (run),
    .credit_load_o (credit_load),
    .credit_slot_o (credit_slot),
    .credit_sent_o (credit_sent),
    .credit_ch_o   (credit_ch)
  );

  ct_credit_counter u_credits
  (
    .core_clk_i    (core_clk_i),
    .arst_n_i      (arst_n_i),
    .credit_load_i (credit_load),
    .send_i        (send),
    .send_ch_i     (send_ch),
    .ret_v_i       (ret_v),
    .ret_ch_i      (ret_ch),
    .ret_cnt_i     (ret_cnt),
    .has_credit_o  (has_credit)
  );

  ct_tx_mux u_tx
  (
    .core_clk_i    (core_clk_i),
    .arst_n_i      (arst_n_i),
    .run_i         (run),
    .credit_slot_i (credit_slot),
    .credit_ch_i   (credit_ch),
    .credit_cnt_i  (owe_count),
    .in_v_i        (in_v_i),
    .in_data_i     (in_data_i),
    .has_credit_i  (has_credit),
    .in_ready_o    (in_ready_o),
    .send_o        (send),
    .send_ch_o     (send_ch),
    .link_v_o      (link_v_o),
    .link_data_o   (link_data_o)
  );

  ct_rx_demux u_rx
  (
    .link_v_i    (link_v_i),
    .link_data_i (link_data_i),
    .wr_v_o      (wr_v),
    .wr_data_o   (wr_data),
    .ret_v_o     (ret_v),
    .ret_ch_o    (ret_ch),
    .ret_cnt_o   (ret_cnt)
  );

  // One receive buffer per logical channel.
  for (genvar c = 0; c < `CT_NUM_CH; c++)
  begin : g_chan
    ct_chan_fifo u_fifo
    (
      .core_clk_i    (core_clk_i),
      .arst_n_i      (arst_n_i),
      .wr_v_i        (wr_v[c]),
      .wr_data_i     (wr_data[c]),
      .out_ready_i   (out_ready_i[c]),
      .credit_sent_i (credit_sent[c]),
      .out_v_o       (out_v_o[c]),
      .out_data_o    (out_data_o[c]),
      .owe_count_o   (owe_count[c]),
      .empty_o       (empty[c])
    );
  end

endmodule

// ==== design/ct_tx_mux.sv ====
`timescale 1ns/1ps
`include "ct_macros.svh"

module ct_tx_mux
(
  input  logic                                          core_clk_i,
  input  logic                                          arst_n_i,
  input  logic                                          run_i,
  input  logic                                          credit_slot_i,
  input  ct_pkg::ch_id_t                                credit_ch_i,
  input  ct_pkg::cnt_t [`CT_NUM_CH-1:0]                 credit_cnt_i,
  input  logic [`CT_NUM_CH-1:0]                         in_v_i,
  input  logic [`CT_NUM_CH-1:0][`CT_PAYLOAD_W-1:0]      in_data_i,
  input  logic [`CT_NUM_CH-1:0]                         has_credit_i,
  output logic [`CT_NUM_CH-1:0]                         in_ready_o,
  output logic                                          send_o,
  output ct_pkg::ch_id_t                                send_ch_o,
  output logic                                          link_v_o,
  output ct_pkg::link_word_s                            link_data_o
);

  import ct_pkg::*;

  ch_id_t rr_ptr_q;

  // Ready is offered up to and including the first valid channel with credit.
  always_comb
  begin : arb
    ch_id_t idx;
    logic   blocked;
    blocked    = 1'b0;
    in_ready_o = '0;
    send_o     = 1'b0;
    send_ch_o  = '0;
    for (int i = 0; i < `CT_NUM_CH; i++)
    begin
      idx = rr_ptr_q + ch_id_t'(i);
      if (run_i && !credit_slot_i && !blocked && has_credit_i[idx])
      begin
        in_ready_o[idx] = 1'b1;
        if (in_v_i[idx])
        begin
          blocked   = 1'b1;
          send_o    = 1'b1;
          send_ch_o = idx;
        end
      end
    end
  end

  always_ff @(posedge core_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      rr_ptr_q <= '0;
      link_v_o <= 1'b0;
    end
    else
    begin
      link_v_o <= credit_slot_i || send_o;
      if (send_o)
      begin
        rr_ptr_q <= send_ch_o + ch_id_t'(1);
      end
    end
  end

  always_ff @(posedge core_clk_i)
  begin
    if (credit_slot_i)
    begin
      link_data_o.kind              <= flit_credit;
      link_data_o.body.credit.ch    <= credit_ch_i;
      link_data_o.body.credit.cnt   <= credit_cnt_i[credit_ch_i];
      link_data_o.body.credit.pad   <= '0;
    end
    else if (send_o)
    begin
      link_data_o.kind              <= flit_data;
      link_data_o.body.data.ch      <= send_ch_o;
      link_data_o.body.data.payload <= in_data_i[send_ch_o];
    end
  end

endmodule

// ==== verif/ct_tunnel_checker.sv ====
`timescale 1ns/1ps
`include "ct_macros.svh"

module ct_tunnel_checker
(
  input  logic                                      core_clk_i,
  input  logic                                      arst_n_i,
  input  string                                     test_name_i,
  input  logic                                      lat_check_i,
  input  logic [`CT_NUM_CH-1:0]                     stall_i,
  input  logic                                      end_i,
  input  logic [`CT_NUM_CH-1:0]                     in_v_i,
  input  logic [`CT_NUM_CH-1:0][`CT_PAYLOAD_W-1:0]  in_data_i,
  input  logic [`CT_NUM_CH-1:0]                     in_ready_i,
  input  logic [`CT_NUM_CH-1:0]                     out_v_i,
  input  logic [`CT_NUM_CH-1:0][`CT_PAYLOAD_W-1:0]  out_data_i,
  input  logic [`CT_NUM_CH-1:0]                     out_ready_i,
  input  logic                                      link_v_i,
  output int                                        pending_o,
  output int                                        value_errs_o,
  output int                                        other_errs_o
);

  logic [`CT_PAYLOAD_W-1:0] exp_q [`CT_NUM_CH][$];
  int                       stamp_q [`CT_NUM_CH][$];
  int                       stall_cnt [`CT_NUM_CH];
  logic [`CT_NUM_CH-1:0]    stall_q = '0;
  logic [`CT_NUM_CH-1:0]    ready_seen = '0;
  logic                     end_q = 1'b0;
  int                       cycle = 0;
  int                       pending = 0;
  int                       value_errs = 0;
  int                       other_errs = 0;

  assign pending_o    = pending;
  assign value_errs_o = value_errs;
  assign other_errs_o = other_errs;

  // Sampled on the falling edge well away from the rising edge and the input drive.
  always @(negedge core_clk_i)
  begin : sample
    logic [`CT_PAYLOAD_W-1:0] exp_data;
    int                       lat;
    cycle++;
    if (!arst_n_i)
    begin
      for (int c = 0; c < `CT_NUM_CH; c++)
      begin
        stall_cnt[c] = 0;
      end
      if ((in_ready_i !== '0) || (out_v_i !== '0) || (link_v_i !== 1'b0))
      begin
        other_errs++;
        $display("Error: ready or valid output high during reset, cycle %0d", cycle);
      end
    end
    else
    begin
      // Ready offered with no traffic pending.
      if (in_v_i == '0)
      begin
        ready_seen = ready_seen | in_ready_i;
      end
      for (int c = 0; c < `CT_NUM_CH; c++)
      begin
        // Pop before push.
        if (out_v_i[c] && out_ready_i[c])
        begin
          if (exp_q[c].size() == 0)
          begin
            other_errs++;
            $display("Error in %s: channel %0d delivered a flit that was never sent",
                     test_name_i, c);
          end
          else
          begin
            exp_data = exp_q[c].pop_front();
            lat      = cycle - stamp_q[c].pop_front();
            if (out_data_i[c] !== exp_data)
            begin
              value_errs++;
              $display("FAIL %s: ch %0d data expected %h, actual %h",
                       test_name_i, c, exp_data, out_data_i[c]);
            end
            if (lat_check_i && (lat != 2))
            begin
              value_errs++;
              $display("FAIL %s: ch %0d latency expected 2, actual %0d", test_name_i, c, lat);
            end
          end
        end
        if (in_v_i[c] && in_ready_i[c])
        begin
          exp_q[c].push_back(in_data_i[c]);
          stamp_q[c].push_back(cycle);
          if (stall_i[c])
          begin
            stall_cnt[c]++;
          end
        end
        // A stalled channel takes exactly one buffer's worth of flits.
        if (stall_q[c] && !stall_i[c] && (stall_cnt[c] != `CT_FIFO_DEPTH))
        begin
          value_errs++;
          $display("FAIL %s: ch %0d flits accepted while stalled expected %0d, actual %0d",
                   test_name_i, c, `CT_FIFO_DEPTH, stall_cnt[c]);
        end
        if (!stall_i[c])
        begin
          stall_cnt[c] = 0;
        end
      end
      if (end_i && !end_q)
      begin
        if (ready_seen != '1)
        begin
          other_errs++;
          $display("Error: in_ready never rose on some idle channels, seen mask %b",
                   ready_seen);
        end
        for (int c = 0; c < `CT_NUM_CH; c++)
        begin
          if (exp_q[c].size() != 0)
          begin
            other_errs++;
            $display("Error: channel %0d still has %0d flits undelivered", c, exp_q[c].size());
          end
        end
      end
    end
    stall_q = stall_i;
    end_q   = end_i;
    pending = 0;
    for (int c = 0; c < `CT_NUM_CH; c++)
    begin
      pending += exp_q[c].size();
    end
  end

endmodule

// ==== verif/ct_tunnel_tb.sv ====
`timescale 1ns/1ps
`include "ct_macros.svh"

module ct_tunnel_tb;

  import ct_pkg::*;

  localparam int num_tests  = 5;
  localparam int rdy_always = 0;
  localparam int rdy_never  = 1;
  localparam int rdy_random = 2;

  // One row per test with name, channel mask, flits per channel and out_ready pattern.
  // The never pattern stalls the lowest channel in the mask.
  string                 row_name  [num_tests] = '{"single", "all_ch", "stall", "random",
                                                   "single_end"};
  logic [`CT_NUM_CH-1:0] row_mask  [num_tests] = '{4'b0100, 4'b1111, 4'b1011, 4'b1111,
                                                   4'b0001};
  int                    row_flits [num_tests] = '{1, 12, 10, 40, 1};
  int                    row_rdy   [num_tests] = '{rdy_always, rdy_always, rdy_never,
                                                   rdy_random, rdy_always};

  logic                                      core_clk = 1'b0;
  logic                                      arst_n = 1'b1;
  logic [`CT_NUM_CH-1:0]                     in_v = '0;
  logic [`CT_NUM_CH-1:0][`CT_PAYLOAD_W-1:0]  in_data = '0;
  logic [`CT_NUM_CH-1:0]                     in_ready;
  logic [`CT_NUM_CH-1:0]                     out_v;
  logic [`CT_NUM_CH-1:0][`CT_PAYLOAD_W-1:0]  out_data;
  logic [`CT_NUM_CH-1:0]                     out_ready = '1;
  logic                                      link_v;
  link_word_s                                link_data;
  string                                     test_name = "reset";
  logic                                      lat_check = 1'b0;
  logic [`CT_NUM_CH-1:0]                     stall = '0;
  logic                                      end_run = 1'b0;
  int                                        pending;
  int                                        value_errs;
  int                                        other_errs;
  int                                        next_seq [`CT_NUM_CH];

  always #2 core_clk = ~core_clk;

  // Link output loops straight back to the link input.
  ct_tunnel_top dut0
  (
    .core_clk_i  (core_clk),
    .arst_n_i    (arst_n),
    .in_v_i      (in_v),
    .in_data_i   (in_data),
    .in_ready_o  (in_ready),
    .out_v_o     (out_v),
    .out_data_o  (out_data),
    .out_ready_i (out_ready),
    .link_v_o    (link_v),
    .link_data_o (link_data),
    .link_v_i    (link_v),
    .link_data_i (link_data)
  );

  ct_tunnel_checker u_check
  (
    .core_clk_i   (core_clk),
    .arst_n_i     (arst_n),
    .test_name_i  (test_name),
    .lat_check_i  (lat_check),
    .stall_i      (stall),
    .end_i        (end_run),
    .in_v_i       (in_v),
    .in_data_i    (in_data),
    .in_ready_i   (in_ready),
    .out_v_i      (out_v),
    .out_data_i   (out_data),
    .out_ready_i  (out_ready),
    .link_v_i     (link_v),
    .pending_o    (pending),
    .value_errs_o (value_errs),
    .other_errs_o (other_errs)
  );

  task automatic run_test(input int t);
    int                    left [`CT_NUM_CH];
    int                    stall_ch;
    int                    quiet;
    logic                  busy;
    logic                  others_idle;
    logic [`CT_NUM_CH-1:0] fire;
    test_name = row_name[t];
    lat_check = (row_flits[t] == 1);
    stall_ch  = -1;
    quiet     = 0;
    busy      = 1'b1;
    for (int c = `CT_NUM_CH - 1; c >= 0; c--)
    begin
      left[c] = row_mask[t][c] ? row_flits[t] : 0;
      if (row_mask[t][c] && (row_rdy[t] == rdy_never))
      begin
        stall_ch = c;
      end
    end
    if (stall_ch >= 0)
    begin
      stall[stall_ch]     = 1'b1;
      out_ready[stall_ch] = 1'b0;
    end
    while (busy)
    begin
      // Payload is channel id over sequence number.
      for (int c = 0; c < `CT_NUM_CH; c++)
      begin
        in_v[c]    = (left[c] != 0);
        in_data[c] = {4'(c), 12'(next_seq[c])};
      end
      @(negedge core_clk);
      fire = in_v & in_ready;
      if (stall_ch >= 0)
      begin
        quiet = in_ready[stall_ch] ? 0 : quiet + 1;
      end
      @(posedge core_clk);
      #1;
      busy        = 1'b0;
      others_idle = 1'b1;
      for (int c = 0; c < `CT_NUM_CH; c++)
      begin
        if (fire[c])
        begin
          left[c]--;
          next_seq[c]++;
        end
        busy = busy || (left[c] != 0);
        if ((c != stall_ch) && (left[c] != 0))
        begin
          others_idle = 1'b0;
        end
        if ((row_rdy[t] == rdy_random) && row_mask[t][c])
        begin
          out_ready[c] = ($urandom % 4) != 0;
        end
      end
      // Release once the stalled channel is out of credits and alone.
      if ((stall_ch >= 0) && stall[stall_ch] && others_idle && (quiet >= 10))
      begin
        stall[stall_ch]     = 1'b0;
        out_ready[stall_ch] = 1'b1;
      end
    end
    in_v      = '0;
    stall     = '0;
    out_ready = '1;
    @(posedge core_clk);
    while (pending != 0)
    begin
      @(posedge core_clk);
    end
    #1;
    lat_check = 1'b0;
    // Let the last credit flits go home.
    repeat (8) @(posedge core_clk);
    #1;
  endtask

  initial
  begin : main
    void'($urandom(59440));
    #1;
    arst_n = 1'b0;
    repeat (8) @(posedge core_clk);
    #1;
    arst_n = 1'b1;
    for (int t = 0; t < num_tests; t++)
    begin
      run_test(t);
    end
    end_run = 1'b1;
    repeat (2) @(posedge core_clk);
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if ((value_errs == 0) && (other_errs == 0))
    begin
      $display("Done: no errors");
    end
    else
    begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial
  begin : watchdog
    int total;
    int limit;
    total = 0;
    for (int t = 0; t < num_tests; t++)
    begin
      for (int c = 0; c < `CT_NUM_CH; c++)
      begin
        total += row_mask[t][c] ? row_flits[t] : 0;
      end
    end
    limit = total * 20 + 200;
    repeat (limit) @(posedge core_clk);
    $display("Timeout: run did not finish within %0d cycles", limit);
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    $display("Done: errors found");
    $finish;
  end

endmodule
